// ==== include/sram_subsystem_config.svh ====
`ifndef SRAM_SUBSYSTEM_CONFIG_SVH
`define SRAM_SUBSYSTEM_CONFIG_SVH

// OBI bus widths
`define OBI_ADDR_W 32
`define OBI_DATA_W 32
`define OBI_BE_W   4

// Shared SRAM bank, depth in words
`define SRAM_WORDS 256

// Byte address of the first SRAM word
`define SRAM_BASE 32'h8000_0000

// Host window, low bound inclusive and high bound exclusive.
// Host addresses in here land in the SRAM region.
`define HOST_WIN_LO 32'h3000_0000
`define HOST_WIN_HI 32'h8000_0000

`endif

// ==== logic/obi_pkg.sv ====
`include "sram_subsystem_config.svh"

package obi_pkg;

    // Bus payload types
    typedef logic [`OBI_ADDR_W-1:0] obi_addr_t;
    typedef logic [`OBI_DATA_W-1:0] obi_data_t;
    typedef logic [`OBI_BE_W-1:0]   obi_be_t;

    // Word index into the SRAM bank
    typedef logic [$clog2(`SRAM_WORDS)-1:0] sram_index_t;

    // Wishbone to OBI bridge sequence
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        ACK
    } bridge_state_e;

    // Requester that a pending response belongs to
    typedef enum logic {
        HOST,
        LOCAL
    } owner_e;

endpackage

// ==== logic/obi_bus_if.sv ====
`timescale 1ns/1ps

interface obi_bus_if
    import obi_pkg::*;
();

    // Address phase
    logic      req;
    logic      gnt;
    obi_addr_t addr;
    logic      we;
    obi_be_t   be;
    obi_data_t wdata;

    // Response phase
    logic      rvalid;
    obi_data_t rdata;

    modport requester (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport responder (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// ==== logic/wb_obi_bridge.sv ====
`timescale 1ns/1ps

`include "sram_subsystem_config.svh"

module wb_obi_bridge
    import obi_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    // Wishbone classic slave
    input  logic         wbs_cyc_i,
    input  logic         wbs_stb_i,
    input  logic         wbs_we_i,
    input  obi_be_t      wbs_sel_i,
    input  obi_addr_t    wbs_adr_i,
    input  obi_data_t    wbs_dat_i,
    output logic         wbs_ack_o,
    output obi_data_t    wbs_dat_o,

    // OBI towards the arbiter
    obi_bus_if.requester obi
);

    bridge_state_e state_q;
    bridge_state_e state_d;
    logic          start;

    obi_addr_t addr_q;
    logic      we_q;
    obi_be_t   be_q;
    obi_data_t wdata_q;
    obi_data_t rdata_q;

    // New Wishbone cycle seen while idle
    assign start = (state_q == IDLE) && wbs_cyc_i && wbs_stb_i;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (obi.gnt) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (obi.rvalid) begin
                    state_d = ACK;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Capture the Wishbone request, held until the grant
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q  <= wbs_adr_i;
            we_q    <= wbs_we_i;
            be_q    <= wbs_sel_i;
            wdata_q <= wbs_dat_i;
        end
        if (state_q == WAIT && obi.rvalid) begin
            rdata_q <= obi.rdata;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign obi.req   = (state_q == REQ);
    assign obi.addr  = addr_q;
    assign obi.we    = we_q;
    assign obi.be    = be_q;
    assign obi.wdata = wdata_q;

    assign wbs_ack_o = (state_q == ACK);
    assign wbs_dat_o = rdata_q;

    // The host keeps its strobe up until it has seen the ack
    ack_inside_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        wbs_ack_o |-> (wbs_cyc_i && wbs_stb_i))
        else $error("wbs_ack_o high outside a Wishbone cycle");

endmodule

// ==== logic/obi_arbiter.sv ====
`timescale 1ns/1ps

`include "sram_subsystem_config.svh"

module obi_arbiter
    import obi_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         host_enable_i,

    // Host requester, from the Wishbone bridge
    obi_bus_if.responder host,

    // Local requester
    input  logic         local_req_i,
    output logic         local_gnt_o,
    input  obi_addr_t    local_addr_i,
    input  logic         local_we_i,
    input  obi_be_t      local_be_i,
    input  obi_data_t    local_wdata_i,
    output logic         local_rvalid_o,
    output obi_data_t    local_rdata_o,

    // Shared path to the SRAM
    obi_bus_if.requester mem
);

    // Top nibble of the SRAM region, put on remapped host addresses
    localparam logic [3:0] REMAP_NIBBLE = 4'(`SRAM_BASE >> (`OBI_ADDR_W - 4));

    logic      host_req;
    logic      host_in_win;
    obi_addr_t host_addr;

    logic      rsp_valid_q;
    owner_e    owner_q;

    //////////////////////////////
    // Host remap
    //////////////////////////////

    // Host only takes part while enabled
    assign host_req = host.req && host_enable_i;

    assign host_in_win = (host.addr >= `HOST_WIN_LO) && (host.addr < `HOST_WIN_HI);

    always_comb begin
        if (host_in_win) begin
            host_addr = {REMAP_NIBBLE, host.addr[`OBI_ADDR_W-5:0]};
        end else begin
            host_addr = host.addr;
        end
    end

    //////////////////////////////
    // Address phase
    //////////////////////////////

    // Host wins a tie, local waits with req held
    assign mem.req   = host_req || local_req_i;
    assign mem.addr  = host_req ? host_addr   : local_addr_i;
    assign mem.we    = host_req ? host.we     : local_we_i;
    assign mem.be    = host_req ? host.be     : local_be_i;
    assign mem.wdata = host_req ? host.wdata  : local_wdata_i;

    assign host.gnt    = host_req && mem.gnt;
    assign local_gnt_o = local_req_i && !host_req && mem.gnt;

    //////////////////////////////
    // Response routing
    //////////////////////////////

    // One entry is enough since the SRAM answers in the next cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            owner_q     <= HOST;
        end else begin
            rsp_valid_q <= mem.req && mem.gnt;
            if (mem.req && mem.gnt) begin
                owner_q <= host_req ? HOST : LOCAL;
            end
        end
    end

    assign host.rvalid    = mem.rvalid && rsp_valid_q && (owner_q == HOST);
    assign local_rvalid_o = mem.rvalid && rsp_valid_q && (owner_q == LOCAL);

    assign host.rdata    = mem.rdata;
    assign local_rdata_o = mem.rdata;

    grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        !(host.gnt && local_gnt_o))
        else $error("host and local granted in the same cycle");

    host_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        host.rvalid |-> $past(host.gnt))
        else $error("host rvalid without a host grant one cycle before");

    local_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        local_rvalid_o |-> $past(local_gnt_o))
        else $error("local rvalid without a local grant one cycle before");

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ps

`include "sram_subsystem_config.svh"

module sram_bank
    import obi_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    obi_bus_if.responder obi,

    output logic         illegal_access_o
);

    localparam int        BYTE_OFS_W = $clog2(`OBI_BE_W);
    localparam obi_addr_t SRAM_BYTES = obi_addr_t'(`SRAM_WORDS * `OBI_BE_W);

    obi_data_t   mem_q [`SRAM_WORDS];
    obi_addr_t   offset;
    sram_index_t index;
    logic        in_range;
    logic        access;

    obi_data_t   rdata_q;
    logic        rvalid_q;
    logic        illegal_q;

    // Never stalls
    assign obi.gnt = obi.req;
    assign access  = obi.req && obi.gnt;

    // Byte offset from the base, a wrap below the base also ends up out of range
    assign offset   = obi.addr - `SRAM_BASE;
    assign in_range = (offset < SRAM_BYTES);
    assign index    = offset[BYTE_OFS_W +: $bits(sram_index_t)];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (access && in_range && obi.we) begin
            for (int b = 0; b < `OBI_BE_W; b++) begin
                if (obi.be[b]) begin
                    mem_q[index][b*8 +: 8] <= obi.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read word, zero for writes and for misses
    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= (in_range && !obi.we) ? mem_q[index] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            rvalid_q  <= access;
            illegal_q <= access && !in_range;
        end
    end

    assign obi.rvalid       = rvalid_q;
    assign obi.rdata        = rdata_q;
    assign illegal_access_o = illegal_q;

    rsp_one_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        obi.rvalid |-> $past(obi.req && obi.gnt))
        else $error("SRAM rvalid without a grant one cycle before");

endmodule

// ==== logic/sram_subsystem.sv ====
`timescale 1ns/1ps

`include "sram_subsystem_config.svh"

module sram_subsystem
    import obi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      host_enable_i,

    // Wishbone host port
    input  logic      wbs_cyc_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_we_i,
    input  obi_be_t   wbs_sel_i,
    input  obi_addr_t wbs_adr_i,
    input  obi_data_t wbs_dat_i,
    output logic      wbs_ack_o,
    output obi_data_t wbs_dat_o,

    // Local OBI port
    input  logic      local_req_i,
    output logic      local_gnt_o,
    input  obi_addr_t local_addr_i,
    input  logic      local_we_i,
    input  obi_be_t   local_be_i,
    input  obi_data_t local_wdata_i,
    output logic      local_rvalid_o,
    output obi_data_t local_rdata_o,

    // SRAM access outside its range
    output logic      illegal_access_o
);

    //////////////////////////////
    // Buses
    //////////////////////////////

    // Bridge to arbiter
    obi_bus_if host_bus ();

    // Arbiter to SRAM
    obi_bus_if mem_bus ();

    //////////////////////////////
    // Host side
    //////////////////////////////

    wb_obi_bridge u_bridge (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .obi       (host_bus)
    );

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    obi_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .host_enable_i  (host_enable_i),
        .host           (host_bus),
        .local_req_i    (local_req_i),
        .local_gnt_o    (local_gnt_o),
        .local_addr_i   (local_addr_i),
        .local_we_i     (local_we_i),
        .local_be_i     (local_be_i),
        .local_wdata_i  (local_wdata_i),
        .local_rvalid_o (local_rvalid_o),
        .local_rdata_o  (local_rdata_o),
        .mem            (mem_bus)
    );

    //////////////////////////////
    // Memory
    //////////////////////////////

    sram_bank u_sram (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .obi              (mem_bus),
        .illegal_access_o (illegal_access_o)
    );

endmodule

// ==== verification/sram_subsystem_tb.sv ====
`timescale 1ns/1ps

`include "sram_subsystem_config.svh"

module sram_subsystem_tb
    import obi_pkg::*;
();

    localparam int          CLK_PERIOD      = 40;
    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 200;
    localparam int unsigned SEED            = 32'h5a2d;

    logic      clk;
    logic      rst;
    logic      host_enable;
    logic      wbs_cyc;
    logic      wbs_stb;
    logic      wbs_we;
    obi_be_t   wbs_sel;
    obi_addr_t wbs_adr;
    obi_data_t wbs_dat_w;
    logic      wbs_ack;
    obi_data_t wbs_dat_r;
    logic      local_req;
    logic      local_gnt;
    obi_addr_t local_addr;
    logic      local_we;
    obi_be_t   local_be;
    obi_data_t local_wdata;
    logic      local_rvalid;
    obi_data_t local_rdata;
    logic      illegal_access;

    int err_count    = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_err_base = 0;

    // Expected SRAM contents
    obi_data_t ref_mem [`SRAM_WORDS];

    sram_subsystem dut_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .host_enable_i    (host_enable),
        .wbs_cyc_i        (wbs_cyc),
        .wbs_stb_i        (wbs_stb),
        .wbs_we_i         (wbs_we),
        .wbs_sel_i        (wbs_sel),
        .wbs_adr_i        (wbs_adr),
        .wbs_dat_i        (wbs_dat_w),
        .wbs_ack_o        (wbs_ack),
        .wbs_dat_o        (wbs_dat_r),
        .local_req_i      (local_req),
        .local_gnt_o      (local_gnt),
        .local_addr_i     (local_addr),
        .local_we_i       (local_we),
        .local_be_i       (local_be),
        .local_wdata_i    (local_wdata),
        .local_rvalid_o   (local_rvalid),
        .local_rdata_o    (local_rdata),
        .illegal_access_o (illegal_access)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void log_mismatch(input string name, input logic [31:0] expected,
                                         input logic [31:0] actual);
        $display("Mismatch at %0t: %s expected 0x%08h, actual 0x%08h",
                 $time, name, expected, actual);
        err_count++;
    endfunction

    function automatic void report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        err_count++;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic obi_addr_t host_to_sram(input obi_addr_t addr);
        if (addr >= `HOST_WIN_LO && addr < `HOST_WIN_HI) begin
            return {4'h8, addr[`OBI_ADDR_W-5:0]};
        end
        return addr;
    endfunction

    function automatic logic addr_in_sram(input obi_addr_t addr);
        return (addr >= `SRAM_BASE) && (addr < `SRAM_BASE + `SRAM_WORDS * `OBI_BE_W);
    endfunction

    function automatic void ref_write(input obi_addr_t addr, input obi_be_t be,
                                      input obi_data_t data);
        sram_index_t idx;
        if (!addr_in_sram(addr)) begin
            return;
        end
        idx = sram_index_t'((addr - `SRAM_BASE) >> 2);
        for (int b = 0; b < `OBI_BE_W; b++) begin
            if (be[b]) begin
                ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    function automatic obi_data_t ref_read(input obi_addr_t addr);
        if (!addr_in_sram(addr)) begin
            return '0;
        end
        return ref_mem[sram_index_t'((addr - `SRAM_BASE) >> 2)];
    endfunction

    //////////////////////////////
    // Local OBI port
    //////////////////////////////

    task automatic local_access(input logic we, input obi_addr_t addr, input obi_be_t be,
                                input obi_data_t wdata, output obi_data_t rdata,
                                output int wait_cycles);
        @(posedge clk);
        #2;
        local_req   = 1'b1;
        local_we    = we;
        local_addr  = addr;
        local_be    = be;
        local_wdata = wdata;
        wait_cycles = 0;
        @(negedge clk);
        while (!local_gnt) begin
            wait_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        local_req = 1'b0;
        // Response cycle
        @(negedge clk);
        assert (local_rvalid)
            else report_failure("local_rvalid_o did not follow local_gnt_o by one cycle");
        assert (illegal_access == !addr_in_sram(addr))
            else log_mismatch("illegal_access_o", 32'(!addr_in_sram(addr)),
                              32'(illegal_access));
        rdata = local_rdata;
        if (we) begin
            ref_write(addr, be, wdata);
        end
    endtask

    task automatic local_write(input obi_addr_t addr, input obi_be_t be,
                               input obi_data_t data, output int wait_cycles);
        obi_data_t rdata;
        local_access(1'b1, addr, be, data, rdata, wait_cycles);
    endtask

    task automatic local_read(input obi_addr_t addr, output int wait_cycles);
        obi_data_t expected;
        obi_data_t rdata;
        expected = ref_read(addr);
        local_access(1'b0, addr, '1, '0, rdata, wait_cycles);
        assert (rdata === expected) else log_mismatch("local_rdata_o", expected, rdata);
    endtask

    //////////////////////////////
    // Wishbone host
    //////////////////////////////

    task automatic host_start(input logic we, input obi_addr_t addr, input obi_be_t sel,
                              input obi_data_t data);
        @(posedge clk);
        #2;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_adr   = addr;
        wbs_sel   = sel;
        wbs_dat_w = data;
    endtask

    // Latency counts the edges from the strobe up to the ack
    task automatic host_finish(output obi_data_t rdata, output int latency);
        latency = 0;
        @(negedge clk);
        while (!wbs_ack) begin
            latency++;
            @(negedge clk);
        end
        rdata = wbs_dat_r;
        @(posedge clk);
        #2;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
    endtask

    task automatic host_write(input obi_addr_t addr, input obi_be_t sel,
                              input obi_data_t data, output int latency);
        obi_data_t rdata;
        host_start(1'b1, addr, sel, data);
        host_finish(rdata, latency);
        ref_write(host_to_sram(addr), sel, data);
    endtask

    task automatic host_read(input obi_addr_t addr, output int latency);
        obi_data_t expected;
        obi_data_t rdata;
        expected = ref_read(host_to_sram(addr));
        host_start(1'b0, addr, '1, '0);
        host_finish(rdata, latency);
        assert (rdata === expected) else log_mismatch("wbs_dat_o", expected, rdata);
    endtask

    //////////////////////////////
    // Protocol checks
    //////////////////////////////

    reset_outputs_low: assert property (@(posedge clk) (rst && $past(rst)) |->
        !(wbs_ack || local_gnt || local_rvalid || illegal_access))
        else report_failure("an output was high during reset");

    local_rsp_timing: assert property (@(posedge clk) disable iff (rst)
        local_gnt |=> local_rvalid)
        else report_failure("local_rvalid_o missing one cycle after local_gnt_o");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wbs_ack |=> !wbs_ack)
        else report_failure("wbs_ack_o high for more than one cycle");

    task automatic start_test();
        test_err_base = err_count;
    endtask

    task automatic close_test(input string name);
        int errs;
        errs = err_count - test_err_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "passed" : "FAILED", errs);
    endtask

    initial begin : watchdog
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired at %0t, a test never completed", $time);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        obi_data_t data_a;
        obi_data_t data_b;
        obi_data_t rdata;
        int        lat;
        int        waits;

        void'($urandom(SEED));
        clk         = 1'b0;
        rst         = 1'b1;
        host_enable = 1'b1;
        wbs_cyc     = 1'b0;
        wbs_stb     = 1'b0;
        wbs_we      = 1'b0;
        wbs_sel     = '0;
        wbs_adr     = '0;
        wbs_dat_w   = '0;
        local_req   = 1'b0;
        local_addr  = '0;
        local_we    = 1'b0;
        local_be    = '0;
        local_wdata = '0;

        start_test();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (!(wbs_ack || local_gnt || local_rvalid || illegal_access))
            else report_failure("an output was high right after reset");
        close_test("reset");

        // Full word first so the partial merge has known bytes around it
        start_test();
        local_write(`SRAM_BASE + 32'h20, '1, $urandom, waits);
        local_write(`SRAM_BASE + 32'h20, obi_be_t'($urandom_range(1, 14)), $urandom, waits);
        local_read(`SRAM_BASE + 32'h20, waits);
        close_test("local round trip");

        start_test();
        host_write(32'h3000_0010, '1, $urandom, lat);
        local_read(32'h8000_0010, waits);
        host_read(32'h3000_0010, lat);
        assert (lat == 3) else log_mismatch("wbs_ack_o latency", 32'd3, 32'(lat));
        close_test("host remap");

        // Local asks one edge later so both OBI requests meet in one cycle
        start_test();
        data_a = $urandom;
        data_b = $urandom;
        fork
            begin
                host_write(32'h3000_0040, '1, data_a, lat);
            end
            begin
                @(posedge clk);
                local_write(`SRAM_BASE + 32'h44, '1, data_b, waits);
            end
        join
        assert (waits == 1) else log_mismatch("local_gnt_o wait", 32'd1, 32'(waits));
        assert (lat == 3) else log_mismatch("wbs_ack_o latency", 32'd3, 32'(lat));
        fork
            begin
                host_read(32'h3000_0044, lat);
            end
            begin
                @(posedge clk);
                local_read(`SRAM_BASE + 32'h40, waits);
            end
        join
        assert (waits == 1) else log_mismatch("local_gnt_o wait", 32'd1, 32'(waits));
        close_test("contention");

        start_test();
        @(posedge clk);
        #2;
        host_enable = 1'b0;
        data_a = $urandom;
        host_start(1'b1, 32'h3000_0080, '1, data_a);
        repeat (20) begin
            @(negedge clk);
            assert (!wbs_ack) else report_failure("wbs_ack_o while host_enable_i low");
        end
        @(posedge clk);
        #2;
        host_enable = 1'b1;
        host_finish(rdata, lat);
        ref_write(host_to_sram(32'h3000_0080), '1, data_a);
        host_read(32'h3000_0080, lat);
        close_test("host disabled");

        // SRAM_BASE + 0x400 would alias word 0 if the range check failed
        start_test();
        local_write(`SRAM_BASE, '1, $urandom, waits);
        local_write(`SRAM_BASE + 32'h400, '1, $urandom, waits);
        local_read(`SRAM_BASE + 32'h400, waits);
        local_read(`SRAM_BASE, waits);
        close_test("out of range");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sram_subsystem.f ====
+incdir+include
logic/obi_pkg.sv
logic/obi_bus_if.sv
logic/wb_obi_bridge.sv
logic/obi_arbiter.sv
logic/sram_bank.sv
logic/sram_subsystem.sv
verification/sram_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sram_subsystem_tb \
    -f sram_subsystem.f -o sram_subsystem_sim || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/sram_subsystem_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "Everything OK" && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
